/* verilog/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Instruction fields
`define OPCODE_W 6
`define FUNCT_W 6

// ALU operation selector
`define ALU_OP_W 3

// Datapath mux selects
`define REG_DST_W 3
`define MEM_TO_REG_W 4
`define IORD_W 3
`define PC_SRC_W 2
`define ALU_SRC_B_W 2

`endif

/* verilog/isaPkg.sv */
`default_nettype none

`include "cpu_config.svh"

package isaPkg;

  typedef enum logic [`OPCODE_W-1:0] {
    opRType = 6'b000000,
    opJ     = 6'b000010,
    opJal   = 6'b000011,
    opAddi  = 6'b001000,
    opAddiu = 6'b001001,
    opSlti  = 6'b001010,
    opLui   = 6'b001111,
    opSw    = 6'b101011
  } opcode_e;

  // Only meaningful when opcode is opRType
  typedef enum logic [`FUNCT_W-1:0] {
    fnXchg = 6'b000101,
    fnJr   = 6'b001000,
    fnMfhi = 6'b010000,
    fnMflo = 6'b010010,
    fnAdd  = 6'b100000,
    fnSub  = 6'b100010,
    fnAnd  = 6'b100100,
    fnSlt  = 6'b101010
  } funct_e;

  typedef enum logic [4:0] {
    ikAdd,
    ikSub,
    ikAnd,
    ikSlt,
    ikJr,
    ikMfhi,
    ikMflo,
    ikXchg,
    ikAddi,
    ikAddiu,
    ikSlti,
    ikLui,
    ikSw,
    ikJ,
    ikJal,
    ikInvalid
  } instrKind_e;

endpackage

`default_nettype wire

/* verilog/ctrlPkg.sv */
`default_nettype none

`include "cpu_config.svh"

package ctrlPkg;

  typedef enum logic [4:0] {
    stReset,
    stFetch0,
    stFetch1,
    stFetch2,
    stDecode,
    stAdd,
    stSub,
    stAnd,
    stSlt,
    stJr,
    stMfhi,
    stMflo,
    stXchg,
    stXchg2,
    stAddi,
    stAddiu,
    stSlti,
    stLui,
    stSw,
    stJ,
    stJal,
    stException
  } ctrlState_e;

  typedef enum logic [`ALU_OP_W-1:0] {
    aluPass = 3'b000,
    aluAdd  = 3'b001,
    aluSub  = 3'b010,
    aluAnd  = 3'b011,
    aluSlt  = 3'b111
  } aluOp_e;

  typedef enum logic [`PC_SRC_W-1:0] {
    pcAluResult  = 2'b00,
    pcJumpTarget = 2'b01,
    pcRegA       = 2'b10,
    pcExcVector  = 2'b11
  } pcSource_e;

  typedef enum logic [`MEM_TO_REG_W-1:0] {
    wbAlu      = 4'b0000,
    wbHi       = 4'b0010,
    wbLo       = 4'b0011,
    wbRegB     = 4'b0111,
    wbLui      = 4'b1000,
    wbRegA     = 4'b1001,
    wbLessThan = 4'b1010
  } memToReg_e;

  typedef enum logic [`REG_DST_W-1:0] {
    dstRt = 3'b000,
    dstRd = 3'b001,
    dstRa = 3'b010,
    dstRs = 3'b100
  } regDst_e;

  typedef enum logic [`ALU_SRC_B_W-1:0] {
    srcBReg  = 2'b00,
    srcBFour = 2'b01,
    srcBImm  = 2'b10
  } aluSrcB_e;

  typedef enum logic [`IORD_W-1:0] {
    addrPc  = 3'b011,
    addrAlu = 3'b100
  } iorD_e;

endpackage

`default_nettype wire

/* verilog/instrDecoder.sv */
`default_nettype none

module instrDecoder import isaPkg::*; (
  input  opcode_e    opcode,
  input  funct_e     funct,
  output instrKind_e kind
);

  always_comb begin
    kind = ikInvalid;
    case (opcode)
      opRType: begin
        // R-type is resolved through funct
        case (funct)
          fnAdd:   kind = ikAdd;
          fnSub:   kind = ikSub;
          fnAnd:   kind = ikAnd;
          fnSlt:   kind = ikSlt;
          fnJr:    kind = ikJr;
          fnMfhi:  kind = ikMfhi;
          fnMflo:  kind = ikMflo;
          fnXchg:  kind = ikXchg;
          default: kind = ikInvalid;
        endcase
      end
      opAddi:  kind = ikAddi;
      opAddiu: kind = ikAddiu;
      opSlti:  kind = ikSlti;
      opLui:   kind = ikLui;
      opSw:    kind = ikSw;
      opJ:     kind = ikJ;
      opJal:   kind = ikJal;
      default: kind = ikInvalid;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/controlSequencer.sv */
`default_nettype none

module controlSequencer import isaPkg::*, ctrlPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  instrKind_e kind,
  input  logic       overflow,
  output ctrlState_e state
);

  ctrlState_e nextState;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stReset;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = stFetch0;
    case (state)
      stReset:  nextState = stFetch0;
      stFetch0: nextState = stFetch1;
      stFetch1: nextState = stFetch2;
      stFetch2: nextState = stDecode;
      stDecode: begin
        case (kind)
          ikAdd:   nextState = stAdd;
          ikSub:   nextState = stSub;
          ikAnd:   nextState = stAnd;
          ikSlt:   nextState = stSlt;
          ikJr:    nextState = stJr;
          ikMfhi:  nextState = stMfhi;
          ikMflo:  nextState = stMflo;
          ikXchg:  nextState = stXchg;
          ikAddi:  nextState = stAddi;
          ikAddiu: nextState = stAddiu;
          ikSlti:  nextState = stSlti;
          ikLui:   nextState = stLui;
          ikSw:    nextState = stSw;
          ikJ:     nextState = stJ;
          ikJal:   nextState = stJal;
          default: nextState = stException;
        endcase
      end
      // Signed arithmetic traps on overflow
      stAdd, stSub, stAddi: nextState = overflow ? stException : stFetch0;
      stXchg:      nextState = stXchg2;
      stException: nextState = stFetch0;
      default:     nextState = stFetch0;
    endcase
  end

  // Fetch always completes into decode
  assert property (@(posedge clk) disable iff (reset)
    state == stFetch2 |=> state == stDecode)
    else $error("stFetch2 not followed by stDecode");

  assert property (@(posedge clk) disable iff (reset)
    state == stException |=> state == stFetch0)
    else $error("stException did not return to stFetch0");

endmodule

`default_nettype wire

/* verilog/controlEncoder.sv */
`default_nettype none

module controlEncoder import ctrlPkg::*; (
  input  ctrlState_e state,
  output logic       pcWrite,
  output logic       aWrite,
  output logic       bWrite,
  output logic       epcWrite,
  output logic       irWrite,
  output logic       regWrite,
  output logic       memWrite,
  output aluOp_e     aluOp,
  output logic       aluSrcA,
  output aluSrcB_e   aluSrcB,
  output regDst_e    regDst,
  output memToReg_e  memToReg,
  output iorD_e      iorD,
  output pcSource_e  pcSource
);

  always_comb begin
    pcWrite  = 1'b0;
    aWrite   = 1'b0;
    bWrite   = 1'b0;
    epcWrite = 1'b0;
    irWrite  = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    aluOp    = aluPass;
    // aluSrcA low selects PC, high selects register A
    aluSrcA  = 1'b0;
    aluSrcB  = srcBReg;
    regDst   = dstRt;
    memToReg = wbAlu;
    iorD     = addrPc;
    pcSource = pcAluResult;
    case (state)
      stFetch1: begin
        pcWrite = 1'b1;
        aluOp   = aluAdd;
        aluSrcB = srcBFour;
      end
      stFetch2: irWrite = 1'b1;
      stDecode: begin
        aWrite = 1'b1;
        bWrite = 1'b1;
      end
      stAdd, stSub, stAnd, stSlt: begin
        regWrite = 1'b1;
        aluSrcA  = 1'b1;
        regDst   = dstRd;
        case (state)
          stAdd:   aluOp = aluAdd;
          stSub:   aluOp = aluSub;
          stAnd:   aluOp = aluAnd;
          default: aluOp = aluSlt;
        endcase
        if (state == stSlt) begin
          memToReg = wbLessThan;
        end
      end
      stAddi, stAddiu, stSlti: begin
        regWrite = 1'b1;
        aluSrcA  = 1'b1;
        aluSrcB  = srcBImm;
        aluOp    = (state == stSlti) ? aluSlt : aluAdd;
        memToReg = (state == stSlti) ? wbLessThan : wbAlu;
      end
      stJr: begin
        pcWrite  = 1'b1;
        aluSrcA  = 1'b1;
        pcSource = pcRegA;
      end
      stMfhi, stMflo: begin
        regWrite = 1'b1;
        regDst   = dstRd;
        memToReg = (state == stMfhi) ? wbHi : wbLo;
      end
      // Swap rs and rt over two write cycles
      stXchg: begin
        regWrite = 1'b1;
        memToReg = wbRegA;
      end
      stXchg2: begin
        regWrite = 1'b1;
        regDst   = dstRs;
        memToReg = wbRegB;
      end
      stLui: begin
        regWrite = 1'b1;
        memToReg = wbLui;
      end
      stSw: begin
        memWrite = 1'b1;
        aluOp    = aluAdd;
        aluSrcA  = 1'b1;
        aluSrcB  = srcBImm;
        iorD     = addrAlu;
      end
      stJ: begin
        pcWrite  = 1'b1;
        pcSource = pcJumpTarget;
      end
      // Link value is the already incremented PC
      stJal: begin
        pcWrite  = 1'b1;
        regWrite = 1'b1;
        regDst   = dstRa;
        pcSource = pcJumpTarget;
      end
      // EPC takes PC minus 4, the faulting instruction
      stException: begin
        epcWrite = 1'b1;
        pcWrite  = 1'b1;
        aluOp    = aluSub;
        aluSrcB  = srcBFour;
        pcSource = pcExcVector;
      end
      default: begin
        pcWrite = 1'b0;
      end
    endcase
    assert (!(regWrite && memWrite))
      else $error("regWrite and memWrite both high in state %s", state.name());
  end

endmodule

`default_nettype wire

/* verilog/controlUnit.sv */
`default_nettype none

module controlUnit import isaPkg::*, ctrlPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  opcode_e   opcode,
  input  funct_e    funct,
  input  logic      overflow,
  output logic      pcWrite,
  output logic      aWrite,
  output logic      bWrite,
  output logic      epcWrite,
  output logic      irWrite,
  output logic      regWrite,
  output logic      memWrite,
  output aluOp_e    aluOp,
  output logic      aluSrcA,
  output aluSrcB_e  aluSrcB,
  output regDst_e   regDst,
  output memToReg_e memToReg,
  output iorD_e     iorD,
  output pcSource_e pcSource
);

  instrKind_e kind;
  ctrlState_e state;

  instrDecoder i_decoder (
    .opcode (opcode),
    .funct  (funct),
    .kind   (kind)
  );

  controlSequencer i_sequencer (
    .clk      (clk),
    .reset    (reset),
    .kind     (kind),
    .overflow (overflow),
    .state    (state)
  );

  controlEncoder i_encoder (
    .state    (state),
    .pcWrite  (pcWrite),
    .aWrite   (aWrite),
    .bWrite   (bWrite),
    .epcWrite (epcWrite),
    .irWrite  (irWrite),
    .regWrite (regWrite),
    .memWrite (memWrite),
    .aluOp    (aluOp),
    .aluSrcA  (aluSrcA),
    .aluSrcB  (aluSrcB),
    .regDst   (regDst),
    .memToReg (memToReg),
    .iorD     (iorD),
    .pcSource (pcSource)
  );

endmodule

`default_nettype wire

/* tests/controlUnitTable.svh */
// Execute words, field order: regWrite, memWrite, pcWrite, aluOp, aluSrcB, regDst,
// memToReg, pcSource
localparam ctrlWord_t noWord    = '0;
localparam ctrlWord_t addWord   = '{1'b1, 1'b0, 1'b0, aluAdd, srcBReg, dstRd, wbAlu, pcAluResult};
localparam ctrlWord_t subWord   = '{1'b1, 1'b0, 1'b0, aluSub, srcBReg, dstRd, wbAlu, pcAluResult};
localparam ctrlWord_t andWord   = '{1'b1, 1'b0, 1'b0, aluAnd, srcBReg, dstRd, wbAlu, pcAluResult};
localparam ctrlWord_t sltWord   = '{1'b1, 1'b0, 1'b0, aluSlt, srcBReg, dstRd, wbLessThan,
                                    pcAluResult};
localparam ctrlWord_t jrWord    = '{1'b0, 1'b0, 1'b1, aluPass, srcBReg, dstRt, wbAlu, pcRegA};
localparam ctrlWord_t mfhiWord  = '{1'b1, 1'b0, 1'b0, aluPass, srcBReg, dstRd, wbHi, pcAluResult};
localparam ctrlWord_t mfloWord  = '{1'b1, 1'b0, 1'b0, aluPass, srcBReg, dstRd, wbLo, pcAluResult};
// xchg writes rt from A, then rs from B
localparam ctrlWord_t xchgWord1 = '{1'b1, 1'b0, 1'b0, aluPass, srcBReg, dstRt, wbRegA, pcAluResult};
localparam ctrlWord_t xchgWord2 = '{1'b1, 1'b0, 1'b0, aluPass, srcBReg, dstRs, wbRegB, pcAluResult};
localparam ctrlWord_t addiWord  = '{1'b1, 1'b0, 1'b0, aluAdd, srcBImm, dstRt, wbAlu, pcAluResult};
localparam ctrlWord_t sltiWord  = '{1'b1, 1'b0, 1'b0, aluSlt, srcBImm, dstRt, wbLessThan,
                                    pcAluResult};
localparam ctrlWord_t luiWord   = '{1'b1, 1'b0, 1'b0, aluPass, srcBReg, dstRt, wbLui, pcAluResult};
localparam ctrlWord_t swWord    = '{1'b0, 1'b1, 1'b0, aluAdd, srcBImm, dstRt, wbAlu, pcAluResult};
localparam ctrlWord_t jWord     = '{1'b0, 1'b0, 1'b1, aluPass, srcBReg, dstRt, wbAlu, pcJumpTarget};
localparam ctrlWord_t jalWord   = '{1'b1, 1'b0, 1'b1, aluPass, srcBReg, dstRa, wbAlu, pcJumpTarget};

// Columns: opcode, funct, overflow, how the row ends, execute word, second word
task automatic fillTable();
  addRow(opRType, fnAdd,   ovfLow,  endNormal,  addWord,   noWord);
  addRow(opRType, fnAdd,   ovfHigh, endTrap,    addWord,   noWord);
  addRow(opRType, fnSub,   ovfLow,  endNormal,  subWord,   noWord);
  addRow(opRType, fnSub,   ovfHigh, endTrap,    subWord,   noWord);
  addRow(opRType, fnAnd,   ovfAny,  endNormal,  andWord,   noWord);
  addRow(opRType, fnSlt,   ovfAny,  endNormal,  sltWord,   noWord);
  addRow(opRType, fnJr,    ovfLow,  endNormal,  jrWord,    noWord);
  addRow(opRType, fnMfhi,  ovfLow,  endNormal,  mfhiWord,  noWord);
  addRow(opRType, fnMflo,  ovfLow,  endNormal,  mfloWord,  noWord);
  addRow(opRType, fnXchg,  ovfLow,  endNormal,  xchgWord1, xchgWord2);
  addRow(opAddi,  6'h00,   ovfLow,  endNormal,  addiWord,  noWord);
  addRow(opAddi,  6'h00,   ovfHigh, endTrap,    addiWord,  noWord);
  addRow(opAddiu, 6'h00,   ovfHigh, endNormal,  addiWord,  noWord);
  addRow(opAddiu, 6'h00,   ovfAny,  endNormal,  addiWord,  noWord);
  addRow(opSlti,  6'h00,   ovfLow,  endNormal,  sltiWord,  noWord);
  addRow(opLui,   6'h00,   ovfLow,  endNormal,  luiWord,   noWord);
  addRow(opSw,    6'h00,   ovfLow,  endNormal,  swWord,    noWord);
  addRow(opJ,     6'h00,   ovfLow,  endNormal,  jWord,     noWord);
  addRow(opJal,   6'h00,   ovfLow,  endNormal,  jalWord,   noWord);
  addRow(6'h3f,   6'h00,   ovfAny,  endInvalid, noWord,    noWord);
  addRow(opRType, 6'h01,   ovfAny,  endInvalid, noWord,    noWord);
endtask

/* tests/controlUnitTb.sv */
`default_nettype none

`include "cpu_config.svh"

module controlUnitTb import isaPkg::*, ctrlPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic      regWrite;
    logic      memWrite;
    logic      pcWrite;
    aluOp_e    aluOp;
    aluSrcB_e  aluSrcB;
    regDst_e   regDst;
    memToReg_e memToReg;
    pcSource_e pcSource;
  } ctrlWord_t;

  typedef struct packed {
    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0]  funct;
    logic [1:0]           ovfMode;
    logic [1:0]           endMode;
    ctrlWord_t            first;
    ctrlWord_t            second;
  } row_t;

  localparam logic [1:0] ovfLow = 2'd0;
  localparam logic [1:0] ovfHigh = 2'd1;
  localparam logic [1:0] ovfAny = 2'd2;
  // endTrap takes the exception after execute
  // endInvalid takes it in place of execute
  localparam logic [1:0] endNormal = 2'd0;
  localparam logic [1:0] endTrap = 2'd1;
  localparam logic [1:0] endInvalid = 2'd2;

  logic      clk;
  logic      reset;
  opcode_e   opcode;
  funct_e    funct;
  logic      overflow;
  logic      pcWrite;
  logic      aWrite;
  logic      bWrite;
  logic      epcWrite;
  logic      irWrite;
  logic      regWrite;
  logic      memWrite;
  aluOp_e    aluOp;
  logic      aluSrcA;
  aluSrcB_e  aluSrcB;
  regDst_e   regDst;
  memToReg_e memToReg;
  iorD_e     iorD;
  pcSource_e pcSource;

  row_t        rows[$];
  row_t        cur;
  logic        curOverflow;
  string       stage;
  int          rowCycle;
  int          rowErrors;
  int          errorCount = 0;
  int          rowsPassed = 0;
  int          rowsFailed = 0;
  int          cycleCount = 0;
  int          cycleLimit = 1000;

  controlUnit i_dut (
    .clk      (clk),
    .reset    (reset),
    .opcode   (opcode),
    .funct    (funct),
    .overflow (overflow),
    .pcWrite  (pcWrite),
    .aWrite   (aWrite),
    .bWrite   (bWrite),
    .epcWrite (epcWrite),
    .irWrite  (irWrite),
    .regWrite (regWrite),
    .memWrite (memWrite),
    .aluOp    (aluOp),
    .aluSrcA  (aluSrcA),
    .aluSrcB  (aluSrcB),
    .regDst   (regDst),
    .memToReg (memToReg),
    .iorD     (iorD),
    .pcSource (pcSource)
  );

  task automatic addRow(input logic [`OPCODE_W-1:0] op, input logic [`FUNCT_W-1:0] fn,
                        input logic [1:0] ovfMode, input logic [1:0] endMode,
                        input ctrlWord_t first, input ctrlWord_t second);
    row_t r;
    r.opcode = op;
    r.funct = fn;
    r.ovfMode = ovfMode;
    r.endMode = endMode;
    r.first = first;
    r.second = second;
    rows.push_back(r);
  endtask

  `include "controlUnitTable.svh"

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic expectValue(input string name, input int actual, input int expected);
    if (actual != expected) begin
      $display("[ERROR] %0t: %s cycle %0d: %s is %0d, expected %0d",
               $time, stage, rowCycle, name, actual, expected);
      errorCount++;
      rowErrors++;
    end
  endtask

  task automatic checkEnables(input bit expPc, expA, expB, expEpc, expIr, expReg, expMem);
    expectValue("pcWrite", int'(pcWrite), int'(expPc));
    expectValue("aWrite", int'(aWrite), int'(expA));
    expectValue("bWrite", int'(bWrite), int'(expB));
    expectValue("epcWrite", int'(epcWrite), int'(expEpc));
    expectValue("irWrite", int'(irWrite), int'(expIr));
    expectValue("regWrite", int'(regWrite), int'(expReg));
    expectValue("memWrite", int'(memWrite), int'(expMem));
  endtask

  task automatic checkWord(input ctrlWord_t w);
    checkEnables(w.pcWrite, 1'b0, 1'b0, 1'b0, 1'b0, w.regWrite, w.memWrite);
    expectValue("aluOp", int'(aluOp), int'(w.aluOp));
    expectValue("aluSrcB", int'(aluSrcB), int'(w.aluSrcB));
    expectValue("regDst", int'(regDst), int'(w.regDst));
    expectValue("memToReg", int'(memToReg), int'(w.memToReg));
    expectValue("pcSource", int'(pcSource), int'(w.pcSource));
  endtask

  task automatic checkException();
    checkEnables(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    expectValue("pcSource", int'(pcSource), int'(pcExcVector));
  endtask

  // Outputs are sampled on the falling edge
  task automatic nextCycle();
    @(posedge clk);
    @(negedge clk);
    rowCycle++;
  endtask

  function automatic logic pickOverflow(input logic [1:0] mode);
    if (mode == ovfAny) begin
      return ($urandom % 2) != 0;
    end
    return mode == ovfHigh;
  endfunction

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    opcode = opRType;
    funct = fnAdd;
    overflow = 1'b0;
    void'($urandom(32'ha6f0));
    fillTable();
    cycleLimit = rows.size() * 7 + 20;

    // Third sample falls in the stReset cycle right after reset drops
    stage = "reset";
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i == 2) begin
        reset <= 1'b0;
      end
      @(negedge clk);
      rowCycle = i + 1;
      checkEnables(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end

    // Row 0 cycle 3 is then exactly 3 cycles after reset falls
    foreach (rows[i]) begin
      cur = rows[i];
      rowErrors = 0;
      stage = $sformatf("row %0d", i);
      @(posedge clk);
      curOverflow = pickOverflow(cur.ovfMode);
      opcode <= opcode_e'(cur.opcode);
      funct <= funct_e'(cur.funct);
      overflow <= curOverflow;
      @(negedge clk);
      rowCycle = 1;
      checkEnables(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      expectValue("iorD", int'(iorD), int'(addrPc));
      nextCycle();
      checkEnables(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      expectValue("aluOp", int'(aluOp), int'(aluAdd));
      expectValue("aluSrcA", int'(aluSrcA), 0);
      expectValue("aluSrcB", int'(aluSrcB), int'(srcBFour));
      expectValue("pcSource", int'(pcSource), int'(pcAluResult));
      nextCycle();
      checkEnables(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
      nextCycle();
      checkEnables(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      nextCycle();
      if (cur.endMode == endInvalid) begin
        checkException();
      end else begin
        checkWord(cur.first);
        if (cur.second != noWord) begin
          nextCycle();
          checkWord(cur.second);
        end
        if (cur.endMode == endTrap) begin
          nextCycle();
          checkException();
        end
      end
      if (rowErrors == 0) begin
        rowsPassed++;
      end else begin
        rowsFailed++;
      end
      $display("Row %0d opcode %h funct %h overflow %b: %s", i, cur.opcode, cur.funct,
               curOverflow, (rowErrors == 0) ? "pass" : "fail");
    end

    // Last row must fall back into fetch with no extra exception
    stage = "end";
    nextCycle();
    rowCycle = 1;
    checkEnables(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

    $display("Rows passed %0d, rows failed %0d, errors %0d", rowsPassed, rowsFailed,
             errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
+incdir+tests
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/controlSequencer.sv
verilog/controlEncoder.sv
verilog/controlUnit.sv
tests/controlUnitTb.sv

/* run.sh */
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
if ! verilator --binary --timing --assert -f tb.f --top-module controlUnitTb \
    -o controlUnitSim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/controlUnitSim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "^Test OK$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed"
exit 1
